// ==== common/mul_config.svh ====
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// operand width of the multiplier, in bits.
`define MUL_OP_WIDTH 32

// default uart bit period in clocks.
// 100 MHz system clock at 115200 baud.
`define MUL_CLKS_PER_BIT 868

`endif

// ==== common/mul_pkg.sv ====
`include "mul_config.svh"

package mul_pkg;

   typedef logic [`MUL_OP_WIDTH-1:0]   operand_t;
   typedef logic [2*`MUL_OP_WIDTH-1:0] product_t;
   typedef logic [3:0]                 nibble_t;

   // low nibble of a command byte.
   typedef enum logic [3:0] {
      LOAD_A = 4'd0,
      LOAD_B = 4'd1,
      READ   = 4'd2,
      START  = 4'd3
   } cmd_op_e;

   typedef enum logic {
      LOADING,
      MULTIPLY
   } ctrl_state_e;

endpackage

// ==== common/uart_pkg.sv ====
package uart_pkg;

   typedef logic [7:0] uart_byte_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

endpackage

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps
`include "mul_config.svh"

module uart_rx #(
   parameter int CLKS_PER_BIT = `MUL_CLKS_PER_BIT
) (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_rx,
   output uart_pkg::uart_byte_t o_data,
   output logic                 o_received
);
   import uart_pkg::*;

   localparam int               CNT_W    = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);

   logic [2:0]       rx_sync;
   logic             rx_bit;
   rx_state_e        state;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   logic             bit_end;
   uart_byte_t       shreg;

   // ----------------------------------------------------------------------
   // line resynchronizer, idles high.
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= 3'b111;
      end else begin
         rx_sync <= {rx_sync[1:0], i_rx};
      end
   end

   assign rx_bit  = rx_sync[2];
   assign bit_end = (cnt == LAST_CNT);

   // ----------------------------------------------------------------------
   // frame FSM, each bit is sampled in the middle of its period.
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= RX_IDLE;
         cnt        <= '0;
         bit_idx    <= '0;
         o_received <= 1'b0;
      end else begin
         o_received <= 1'b0;
         case (state)
            RX_IDLE: begin
               cnt     <= '0;
               bit_idx <= '0;
               if (!rx_bit) state <= RX_START;
            end
            RX_START: begin
               if (cnt == HALF_CNT) begin
                  cnt   <= '0;
                  state <= rx_bit ? RX_IDLE : RX_DATA; // short glitch, not a start bit.
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) state <= RX_STOP;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (bit_end) begin
                  state      <= RX_IDLE;
                  o_received <= rx_bit; // bad stop bit drops the byte.
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // lsb arrives first.
   always_ff @(posedge i_clk) begin
      if (state == RX_DATA && bit_end) shreg <= {rx_bit, shreg[7:1]};
   end

   assign o_data = shreg;

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps
`include "mul_config.svh"

module uart_tx #(
   parameter int CLKS_PER_BIT = `MUL_CLKS_PER_BIT
) (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_send,
   input  uart_pkg::uart_byte_t i_data,
   output logic                 o_busy,
   output logic                 o_tx
);
   import uart_pkg::*;

   localparam int               CNT_W    = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

   tx_state_e        state;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   logic             bit_end;
   uart_byte_t       shreg;

   assign bit_end = (cnt == LAST_CNT);
   assign o_busy  = (state != TX_IDLE);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         o_tx    <= 1'b1;
      end else begin
         if (state == TX_IDLE) begin
            cnt     <= '0;
            bit_idx <= '0;
            if (i_send) begin
               state <= TX_START;
               o_tx  <= 1'b0;
            end
         end else if (!bit_end) begin
            cnt <= cnt + 1'b1;
         end else begin
            cnt <= '0;
            case (state)
               TX_START: begin
                  state <= TX_DATA;
                  o_tx  <= shreg[0];
               end
               TX_DATA: begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= TX_STOP;
                     o_tx  <= 1'b1;
                  end else begin
                     o_tx <= shreg[1]; // next bit, before the shift lands.
                  end
               end
               default: state <= TX_IDLE; // end of stop bit.
            endcase
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_send) begin
         shreg <= i_data;
      end else if (state == TX_DATA && bit_end) begin
         shreg <= shreg >> 1;
      end
   end

endmodule

// ==== logic/seq_multiplier.sv ====
`timescale 1ns/1ps
`include "mul_config.svh"

module seq_multiplier #(
   parameter int DATA_WIDTH_A = `MUL_OP_WIDTH,
   parameter int DATA_WIDTH_B = `MUL_OP_WIDTH
) (
   input  logic                               i_clk,
   input  logic                               i_nrst,
   input  logic [DATA_WIDTH_A-1:0]            i_a,
   input  logic [DATA_WIDTH_B-1:0]            i_b,
   input  logic                               i_valid,
   output logic [DATA_WIDTH_A+DATA_WIDTH_B-1:0] o_c,
   output logic                               o_accept
);

   localparam int               C_W       = DATA_WIDTH_A + DATA_WIDTH_B;
   localparam int               CNT_W     = $clog2(DATA_WIDTH_B + 1);
   localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(DATA_WIDTH_B - 1);

   logic             busy;
   logic             load;
   logic [CNT_W-1:0] step;
   logic [C_W-1:0]   mcand;
   logic [C_W-1:0]   acc;
   logic [DATA_WIDTH_B-1:0] mplier;

   // no reload in the accept cycle, i_valid is still high there.
   assign load = i_valid && !busy && !o_accept;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy     <= 1'b0;
         step     <= '0;
         o_accept <= 1'b0;
      end else begin
         o_accept <= 1'b0;
         if (load) begin
            busy <= 1'b1;
            step <= '0;
         end else if (busy) begin
            step <= step + 1'b1;
            if (step == LAST_STEP) begin
               busy     <= 1'b0;
               o_accept <= 1'b1;
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // one multiplier bit per cycle.
   always_ff @(posedge i_clk) begin
      if (load) begin
         mcand  <= C_W'(i_a);
         mplier <= i_b;
         acc    <= '0;
      end else if (busy) begin
         if (mplier[0]) acc <= acc + mcand;
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   assign o_c = acc;

endmodule

// ==== logic/mul_cmd_ctrl.sv ====
`timescale 1ns/1ps

module mul_cmd_ctrl (
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  uart_pkg::uart_byte_t i_rx_data,
   input  logic                 i_rx_received,
   input  logic                 i_tx_busy,
   output uart_pkg::uart_byte_t o_tx_data,
   output logic                 o_send,
   output mul_pkg::operand_t    o_mul_a,
   output mul_pkg::operand_t    o_mul_b,
   output logic                 o_mul_valid,
   input  mul_pkg::product_t    i_mul_c,
   input  logic                 i_mul_accept
);
   import mul_pkg::*;

   localparam int OP_W = $bits(operand_t);

   ctrl_state_e state;
   cmd_op_e     cmd_op;
   nibble_t     cmd_nib;
   logic        cmd_take;
   logic        read_go;
   product_t    result;

   assign cmd_op   = cmd_op_e'(i_rx_data[3:0]);
   assign cmd_nib  = i_rx_data[7:4];
   assign cmd_take = i_rx_received && (state == LOADING); // busy multiplier ignores commands.
   assign read_go  = cmd_take && (cmd_op == READ) && !i_tx_busy;

   assign o_mul_valid = (state == MULTIPLY);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= LOADING;
         o_send <= 1'b0;
         result <= '0;
      end else begin
         o_send <= read_go;
         case (state)
            LOADING: begin
               if (read_go) begin
                  result <= result >> 8;
               end else if (cmd_take && cmd_op == START) begin
                  state <= MULTIPLY;
               end
            end
            MULTIPLY: begin
               if (i_mul_accept) begin
                  result <= i_mul_c;
                  state  <= LOADING;
               end
            end
            default: state <= LOADING;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // operands shift in ms nibble first.
   always_ff @(posedge i_clk) begin
      if (cmd_take && cmd_op == LOAD_A) o_mul_a <= {o_mul_a[OP_W-5:0], cmd_nib};
      if (cmd_take && cmd_op == LOAD_B) o_mul_b <= {o_mul_b[OP_W-5:0], cmd_nib};
      if (read_go) o_tx_data <= result[7:0]; // byte before the shift.
   end

endmodule

// ==== logic/mul_uart_top.sv ====
`timescale 1ns/1ps
`include "mul_config.svh"

module mul_uart_top #(
   parameter int CLKS_PER_BIT = `MUL_CLKS_PER_BIT
) (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_rx,
   output logic o_tx
);
   import uart_pkg::*;
   import mul_pkg::*;

   uart_byte_t rx_data;
   logic       rx_received;
   uart_byte_t tx_data;
   logic       tx_send;
   logic       tx_busy;
   operand_t   mul_a;
   operand_t   mul_b;
   product_t   mul_c;
   logic       mul_valid;
   logic       mul_accept;

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_uart_rx (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_rx         (i_rx),
      .o_data       (rx_data),
      .o_received   (rx_received)
   );

   mul_cmd_ctrl u_cmd_ctrl (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_rx_data     (rx_data),
      .i_rx_received (rx_received),
      .i_tx_busy     (tx_busy),
      .o_tx_data     (tx_data),
      .o_send        (tx_send),
      .o_mul_a       (mul_a),
      .o_mul_b       (mul_b),
      .o_mul_valid   (mul_valid),
      .i_mul_c       (mul_c),
      .i_mul_accept  (mul_accept)
   );

   seq_multiplier #(
      .DATA_WIDTH_A (`MUL_OP_WIDTH),
      .DATA_WIDTH_B (`MUL_OP_WIDTH)
   ) u_mul (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_a          (mul_a),
      .i_b          (mul_b),
      .i_valid      (mul_valid),
      .o_c          (mul_c),
      .o_accept     (mul_accept)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_uart_tx (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_send       (tx_send),
      .i_data       (tx_data),
      .o_busy       (tx_busy),
      .o_tx         (o_tx)
   );

endmodule

// ==== bench/mul_uart_chk.sv ====
`timescale 1ns/1ps

module mul_uart_chk (
   input logic i_clk,
   input logic i_nrst,
   input logic i_mul_valid,
   input logic i_mul_accept,
   input logic i_tx_busy,
   input logic i_tx
);

   int n_fail = 0; // count of failed assertions.

   // ----------------------------------------------------------------------
   // multiplier handshake.
   accept_single: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_mul_accept |=> !i_mul_accept)
      else begin
         $error("multiplier accept lasted two cycles.");
         n_fail++;
      end

   valid_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_mul_valid && !i_mul_accept) |=> i_mul_valid)
      else begin
         $error("multiplier valid dropped before accept.");
         n_fail++;
      end

   valid_released: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_mul_accept |=> !i_mul_valid)
      else begin
         $error("multiplier valid still high after accept.");
         n_fail++;
      end

   // ----------------------------------------------------------------------
   // serial line idles high.
   tx_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_tx_busy |-> i_tx)
      else begin
         $error("serial output low while transmitter idle.");
         n_fail++;
      end

endmodule

bind mul_uart_top mul_uart_chk u_chk (
   .i_clk        (i_clk),
   .i_nrst       (i_nrst),
   .i_mul_valid  (mul_valid),
   .i_mul_accept (mul_accept),
   .i_tx_busy    (tx_busy),
   .i_tx         (o_tx)
);

// ==== bench/mul_uart_tb.sv ====
`timescale 1ns/1ps

module mul_uart_tb;

   localparam int CLKS_PER_BIT  = 8;
   localparam int REPLY_TIMEOUT = 30 * CLKS_PER_BIT; // cycles until a reply start bit.

   logic        i_clk;
   logic        i_nrst;
   logic        i_rx;
   logic        o_tx;
   int          n_tests;
   int          n_errors;
   logic [31:0] rng_state;

   mul_uart_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) UUT (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_rx   (i_rx),
      .o_tx   (o_tx)
   );

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_random(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r         = rng_state;
   endtask

   // ----------------------------------------------------------------------
   // host side of the serial line.
   // every task ends 1 ns after a clock edge.
   task automatic drive_bit(input logic b);
      i_rx = b;
      repeat (CLKS_PER_BIT) @(posedge i_clk);
      #1;
   endtask

   task automatic send_byte(input logic [7:0] data);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++) begin
         drive_bit(data[i]); // lsb first.
      end
      drive_bit(1'b1);
   endtask

   task automatic recv_byte(output logic [7:0] data);
      int waited;
      data   = '0;
      waited = 0;
      while (o_tx !== 1'b0 && waited < REPLY_TIMEOUT) begin
         @(posedge i_clk);
         #1;
         waited++;
      end
      if (o_tx !== 1'b0) begin
         $display("no reply byte on the serial line within %0d cycles", REPLY_TIMEOUT);
         n_errors++;
      end else begin
         repeat (CLKS_PER_BIT / 2) @(posedge i_clk); // middle of the start bit.
         #1;
         for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(posedge i_clk);
            #1;
            data[i] = o_tx;
         end
         repeat (CLKS_PER_BIT) @(posedge i_clk);
         #1;
         if (o_tx !== 1'b1) begin
            $display("reply byte ended without a stop bit");
            n_errors++;
         end
         repeat (CLKS_PER_BIT / 2) @(posedge i_clk);
         #1;
      end
   endtask

   task automatic load_operands(input logic [31:0] a, input logic [31:0] b);
      for (int i = 7; i >= 0; i--) begin
         send_byte({a[i*4 +: 4], 4'h0});
      end
      for (int i = 7; i >= 0; i--) begin
         send_byte({b[i*4 +: 4], 4'h1});
      end
   endtask

   task automatic start_mul();
      send_byte(8'h03);
      repeat (40 * CLKS_PER_BIT) @(posedge i_clk);
      #1;
   endtask

   task automatic read_result(output logic [63:0] r);
      logic [7:0] b;
      r = '0;
      for (int i = 0; i < 8; i++) begin
         send_byte(8'h02);
         recv_byte(b);
         r[i*8 +: 8] = b;
      end
   endtask

   task automatic check_product(input string name, input logic [31:0] a,
                                input logic [31:0] b, input logic [63:0] act);
      logic [63:0] exp;
      exp = {32'd0, a} * {32'd0, b};
      if (act !== exp) begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         n_errors++;
      end
   endtask

   task automatic mul_and_check(input string name, input logic [31:0] a,
                                input logic [31:0] b);
      logic [63:0] r;
      load_operands(a, b);
      start_mul();
      read_result(r);
      check_product(name, a, b, r);
   endtask

   task automatic report_test(input string name, input int errs_before);
      n_tests++;
      if (n_errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, n_errors - errs_before);
      end
   endtask

   // ----------------------------------------------------------------------
   // directed tests.
   task automatic idle_line_quiet();
      int   errs;
      logic seen_low;
      errs     = n_errors;
      seen_low = 1'b0;
      repeat (20 * CLKS_PER_BIT) begin
         @(posedge i_clk);
         #1;
         if (o_tx !== 1'b1 && !seen_low) begin
            $display("ERR idle_line: expected %b, actual %b", 1'b1, o_tx);
            n_errors++;
            seen_low = 1'b1;
         end
      end
      report_test("idle_line", errs);
   endtask

   task automatic directed_products();
      int errs;
      errs = n_errors;
      mul_and_check("3x5", 32'd3, 32'd5);
      mul_and_check("0xdeadbeef", 32'd0, 32'hDEAD_BEEF);
      mul_and_check("max_x_max", 32'hFFFF_FFFF, 32'hFFFF_FFFF);
      report_test("directed", errs);
   endtask

   task automatic random_products();
      int          errs;
      logic [31:0] a;
      logic [31:0] b;
      errs = n_errors;
      for (int i = 0; i < 8; i++) begin
         next_random(a);
         next_random(b);
         mul_and_check($sformatf("random_%0d", i), a, b);
      end
      report_test("random", errs);
   endtask

   task automatic read_drain_restart();
      int          errs;
      logic [31:0] a;
      logic [31:0] b;
      logic [7:0]  extra;
      logic [63:0] r;
      errs = n_errors;
      next_random(a);
      next_random(b);
      mul_and_check("drain_first", a, b);
      send_byte(8'h02); // result is shifted out by now.
      recv_byte(extra);
      if (extra !== 8'h00) begin
         $display("ERR read_drain: expected %h, actual %h", 8'h00, extra);
         n_errors++;
      end
      start_mul();
      read_result(r);
      check_product("drain_restart", a, b, r);
      report_test("read_drain", errs);
   endtask

   task automatic ignored_commands();
      int          errs;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] nib;
      logic [63:0] r;
      errs = n_errors;
      next_random(a);
      next_random(b);
      load_operands(a, b);
      start_mul();
      for (int op = 4; op < 16; op++) begin
         next_random(nib);
         send_byte({nib[3:0], 4'(op)});
      end
      start_mul();
      read_result(r);
      check_product("unknown_ops", a, b, r);

      next_random(a);
      next_random(b);
      load_operands(a, b);
      send_byte(8'h03);
      send_byte(8'h50); // on the line while the multiplier runs.
      send_byte(8'hA1);
      read_result(r);
      check_product("busy_nibbles", a, b, r);
      report_test("ignored_cmds", errs);
   endtask

   initial begin
      i_nrst    = 1'b0;
      i_rx      = 1'b1;
      n_tests   = 0;
      n_errors  = 0;
      rng_state = 32'd89;
      repeat (10) @(posedge i_clk);
      #1;
      i_nrst = 1'b1;

      idle_line_quiet();
      directed_products();
      random_products();
      read_drain_restart();
      ignored_commands();

      if (UUT.u_chk.n_fail != 0) begin
         $display("%0d assertion failures in the bound checker", UUT.u_chk.n_fail);
         n_errors += UUT.u_chk.n_fail;
      end

      $display("tests run: %0d, errors: %0d", n_tests, n_errors);
      if (n_errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+common
common/mul_pkg.sv
common/uart_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
logic/seq_multiplier.sv
logic/mul_cmd_ctrl.sv
logic/mul_uart_top.sv
bench/mul_uart_chk.sv
bench/mul_uart_tb.sv
